// ==== hdl/uart_alu_pkg.sv ====
package uart_alu_pkg;

    // Data path widths
    localparam int NB_DATA   = 8;
    localparam int NB_OPCODE = 6;

    // Serial timing, one bit = OVERSAMPLE * CLKS_PER_TICK clocks
    localparam int OVERSAMPLE    = 16;
    localparam int CLKS_PER_TICK = 4;

    localparam int NB_DIV_CNT  = $clog2(CLKS_PER_TICK);
    localparam int NB_TICK_CNT = $clog2(OVERSAMPLE);
    localparam int NB_BIT_CNT  = $clog2(NB_DATA);

    localparam logic [NB_DIV_CNT-1:0]  DIV_LAST  = NB_DIV_CNT'(CLKS_PER_TICK - 1);
    localparam logic [NB_TICK_CNT-1:0] TICK_MID  = NB_TICK_CNT'(OVERSAMPLE / 2 - 1);
    localparam logic [NB_TICK_CNT-1:0] TICK_LAST = NB_TICK_CNT'(OVERSAMPLE - 1);
    localparam logic [NB_BIT_CNT-1:0]  BIT_LAST  = NB_BIT_CNT'(NB_DATA - 1);

    // UART frame states, shared by receiver and transmitter
    localparam logic [1:0] ST_IDLE  = 2'b00;
    localparam logic [1:0] ST_START = 2'b01;
    localparam logic [1:0] ST_DATA  = 2'b10;
    localparam logic [1:0] ST_STOP  = 2'b11;

    // Operand collector states
    localparam logic [1:0] COL_IDLE  = 2'b00;
    localparam logic [1:0] COL_STORE = 2'b01;
    localparam logic [1:0] COL_ALU   = 2'b10;

    localparam logic [NB_OPCODE-1:0] OP_ADD = 6'b100000;
    localparam logic [NB_OPCODE-1:0] OP_SUB = 6'b100010;
    localparam logic [NB_OPCODE-1:0] OP_AND = 6'b100100;
    localparam logic [NB_OPCODE-1:0] OP_OR  = 6'b100101;
    localparam logic [NB_OPCODE-1:0] OP_XOR = 6'b100110;
    localparam logic [NB_OPCODE-1:0] OP_SRA = 6'b000011;
    localparam logic [NB_OPCODE-1:0] OP_SRL = 6'b000010;
    localparam logic [NB_OPCODE-1:0] OP_NOR = 6'b100111;

endpackage

// ==== hdl/baud_tick_gen.sv ====
`timescale 1ns/1ps

module baud_tick_gen
    import uart_alu_pkg::*;
(
    input  logic i_clk,
    input  logic i_rst,
    output logic o_tick    // One clock wide, every CLKS_PER_TICK clocks
);

    logic [NB_DIV_CNT-1:0] div_cnt;

    always_ff @(posedge i_clk)
    begin
        if (!i_rst)
        begin
            div_cnt <= '0;
            o_tick  <= 1'b0;
        end
        else
        begin
            o_tick <= (div_cnt == DIV_LAST);    // Registered, first tick 4 clocks after reset
            if (div_cnt == DIV_LAST)
                div_cnt <= '0;
            else
                div_cnt <= div_cnt + 1'b1;
        end
    end

endmodule

// ==== hdl/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx
    import uart_alu_pkg::*;
(
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic               i_tick,
    input  logic               i_rx,
    output logic [NB_DATA-1:0] o_data,
    output logic               o_done
);

    logic [1:0]             rx_sync;    // Two flop synchronizer
    logic                   rx_prev;
    logic                   rx_bit;
    logic [1:0]             state;
    logic [NB_TICK_CNT-1:0] tick_cnt;
    logic [NB_BIT_CNT-1:0]  bit_cnt;
    logic [NB_DATA-1:0]     shift;
    logic                   bit_end;

    assign rx_bit  = rx_sync[1];
    assign bit_end = i_tick && (tick_cnt == TICK_LAST);

    always_ff @(posedge i_clk)
    begin
        if (!i_rst)
        begin
            rx_sync <= 2'b11;   // Line idles high
            rx_prev <= 1'b1;
        end
        else
        begin
            rx_sync <= {rx_sync[0], i_rx};
            rx_prev <= rx_bit;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_rst)
        begin
            state    <= ST_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            o_done   <= 1'b0;
        end
        else
        begin
            o_done <= 1'b0;
            case (state)
                ST_IDLE:
                begin
                    if (rx_prev && !rx_bit)    // Falling edge opens a frame
                    begin
                        state    <= ST_START;
                        tick_cnt <= '0;
                    end
                end
                ST_START:
                begin
                    if (i_tick)
                    begin
                        if (tick_cnt == TICK_MID)
                        begin
                            // Still low at mid start bit, otherwise a glitch
                            state    <= rx_bit ? ST_IDLE : ST_DATA;
                            tick_cnt <= '0;
                            bit_cnt  <= '0;
                        end
                        else
                            tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                ST_DATA:
                begin
                    if (bit_end)
                    begin
                        tick_cnt <= '0;
                        if (bit_cnt == BIT_LAST)
                            state <= ST_STOP;
                        else
                            bit_cnt <= bit_cnt + 1'b1;
                    end
                    else if (i_tick)
                        tick_cnt <= tick_cnt + 1'b1;
                end
                ST_STOP:
                begin
                    if (bit_end)
                    begin
                        state    <= ST_IDLE;
                        tick_cnt <= '0;
                        o_done   <= rx_bit;    // Low stop bit drops the byte
                    end
                    else if (i_tick)
                        tick_cnt <= tick_cnt + 1'b1;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // LSB first, shifted in from the top
    always_ff @(posedge i_clk)
    begin
        if (state == ST_DATA && bit_end)
            shift <= {rx_bit, shift[NB_DATA-1:1]};
        if (state == ST_STOP && bit_end && rx_bit)
            o_data <= shift;
    end

endmodule

// ==== hdl/rx_operand_collector.sv ====
`timescale 1ns/1ps

module rx_operand_collector
    import uart_alu_pkg::*;
(
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic [NB_DATA-1:0]   i_data,
    input  logic                 i_done_data,   // Byte strobe from receiver
    output logic [NB_DATA-1:0]   o_a,
    output logic [NB_DATA-1:0]   o_b,
    output logic [NB_OPCODE-1:0] o_op,
    output logic                 o_rx_alu_done  // Operands ready for the ALU
);

    logic [1:0] state;
    logic [1:0] slot;   // 0 = A, 1 = B, 2 = opcode

    always_ff @(posedge i_clk)
    begin
        if (!i_rst)
            state <= COL_IDLE;
        else
        begin
            case (state)
                COL_IDLE:  if (i_done_data) state <= COL_STORE;
                COL_STORE: if (i_done_data && slot == 2'd2) state <= COL_ALU;
                COL_ALU:   state <= i_done_data ? COL_STORE : COL_IDLE;
                default:   state <= COL_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_rst)
        begin
            slot <= 2'd0;
            o_a  <= '0;
            o_b  <= '0;
            o_op <= '0;
        end
        else if (i_done_data)
        begin
            case (slot)
                2'd0:    o_a  <= i_data;
                2'd1:    o_b  <= i_data;
                default: o_op <= i_data[NB_OPCODE-1:0];
            endcase
            slot <= (slot == 2'd2) ? 2'd0 : slot + 1'b1;   // Wrap after each triple
        end
    end

    assign o_rx_alu_done = (state == COL_ALU);

endmodule

// ==== hdl/alu.sv ====
`timescale 1ns/1ps

module alu
    import uart_alu_pkg::*;
(
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic [NB_DATA-1:0]   i_a,
    input  logic [NB_DATA-1:0]   i_b,
    input  logic [NB_OPCODE-1:0] i_op,
    input  logic                 i_valid,
    output logic [NB_DATA-1:0]   o_result,
    output logic                 o_valid
);

    logic [NB_DATA-1:0] alu_out;

    always_comb
    begin
        case (i_op)
            OP_ADD:  alu_out = i_a + i_b;
            OP_SUB:  alu_out = i_a - i_b;   // Wraps mod 256
            OP_AND:  alu_out = i_a & i_b;
            OP_OR:   alu_out = i_a | i_b;
            OP_XOR:  alu_out = i_a ^ i_b;
            OP_SRA:  alu_out = $signed(i_a) >>> i_b[2:0];
            OP_SRL:  alu_out = i_a >> i_b[2:0];
            OP_NOR:  alu_out = ~(i_a | i_b);
            default: alu_out = '0;
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_rst)
            o_valid <= 1'b0;
        else
            o_valid <= i_valid;
    end

    always_ff @(posedge i_clk)
    begin
        if (i_valid)
            o_result <= alu_out;
    end

endmodule

// ==== hdl/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx
    import uart_alu_pkg::*;
(
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic               i_tick,
    input  logic               i_start,
    input  logic [NB_DATA-1:0] i_data,
    output logic               o_tx,
    output logic               o_busy
);

    logic [1:0]             state;
    logic [NB_TICK_CNT-1:0] tick_cnt;
    logic [NB_BIT_CNT-1:0]  bit_cnt;
    logic [NB_DATA-1:0]     shift;
    logic                   start_pending;  // Byte loaded, waiting for next tick
    logic                   accept;
    logic                   bit_end;

    assign o_busy  = start_pending || (state != ST_IDLE);
    assign accept  = i_start && !o_busy;    // Strobes while busy are dropped
    assign bit_end = i_tick && (tick_cnt == TICK_LAST);

    always_ff @(posedge i_clk)
    begin
        if (!i_rst)
        begin
            state         <= ST_IDLE;
            tick_cnt      <= '0;
            bit_cnt       <= '0;
            start_pending <= 1'b0;
            o_tx          <= 1'b1;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    if (start_pending && i_tick)
                    begin
                        state         <= ST_START;
                        tick_cnt      <= '0;
                        start_pending <= 1'b0;
                        o_tx          <= 1'b0;
                    end
                    else if (accept)
                        start_pending <= 1'b1;
                end
                ST_START:
                begin
                    if (bit_end)
                    begin
                        state    <= ST_DATA;
                        tick_cnt <= '0;
                        bit_cnt  <= '0;
                        o_tx     <= shift[0];
                    end
                    else if (i_tick)
                        tick_cnt <= tick_cnt + 1'b1;
                end
                ST_DATA:
                begin
                    if (bit_end)
                    begin
                        tick_cnt <= '0;
                        if (bit_cnt == BIT_LAST)
                        begin
                            state <= ST_STOP;
                            o_tx  <= 1'b1;
                        end
                        else
                        begin
                            bit_cnt <= bit_cnt + 1'b1;
                            o_tx    <= shift[1];   // Next bit before the shift lands
                        end
                    end
                    else if (i_tick)
                        tick_cnt <= tick_cnt + 1'b1;
                end
                ST_STOP:
                begin
                    // Busy until the stop bit has lasted a full bit
                    if (bit_end)
                    begin
                        state    <= ST_IDLE;
                        tick_cnt <= '0;
                    end
                    else if (i_tick)
                        tick_cnt <= tick_cnt + 1'b1;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (accept)
            shift <= i_data;
        else if (state == ST_DATA && bit_end)
            shift <= shift >> 1;
    end

endmodule

// ==== hdl/uart_alu_top.sv ====
`timescale 1ns/1ps

module uart_alu_top
    import uart_alu_pkg::*;
(
    input  logic i_clk,
    input  logic i_rst,
    input  logic i_rx,     // Serial in, idle high
    output logic o_tx      // Serial out, idle high
);

    logic                 tick;
    logic [NB_DATA-1:0]   rx_data;
    logic                 rx_done;
    logic [NB_DATA-1:0]   op_a;
    logic [NB_DATA-1:0]   op_b;
    logic [NB_OPCODE-1:0] opcode;
    logic                 operands_valid;
    logic [NB_DATA-1:0]   result;
    logic                 result_valid;
    logic                 tx_busy;

    baud_tick_gen u_tick_gen (
        .i_clk  (i_clk),
        .i_rst  (i_rst),
        .o_tick (tick)
    );

    uart_rx u_rx (
        .i_clk  (i_clk),
        .i_rst  (i_rst),
        .i_tick (tick),
        .i_rx   (i_rx),
        .o_data (rx_data),
        .o_done (rx_done)
    );

    rx_operand_collector u_collector (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_data        (rx_data),
        .i_done_data   (rx_done),
        .o_a           (op_a),
        .o_b           (op_b),
        .o_op          (opcode),
        .o_rx_alu_done (operands_valid)
    );

    alu u_alu (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_a      (op_a),
        .i_b      (op_b),
        .i_op     (opcode),
        .i_valid  (operands_valid),
        .o_result (result),
        .o_valid  (result_valid)
    );

    // Result strobe doubles as transmit start
    uart_tx u_tx (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_tick  (tick),
        .i_start (result_valid),
        .i_data  (result),
        .o_tx    (o_tx),
        .o_busy  (tx_busy)
    );

endmodule

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen
(
    output logic o_clk,
    output logic o_rst
);

    initial
    begin
        o_clk = 1'b0;
        forever #10 o_clk = ~o_clk;    // 20 ns period
    end

    // Active low, released on a falling edge after 10 cycles
    initial
    begin
        o_rst = 1'b0;
        repeat (10) @(posedge o_clk);
        @(negedge o_clk);
        o_rst = 1'b1;
    end

endmodule

// ==== verification/uart_alu_properties.sv ====
`timescale 1ns/1ps

module uart_alu_properties
(
    input logic i_clk,
    input logic i_rst,
    input logic i_operands_valid,
    input logic i_result_valid,
    input logic i_tx_busy,
    input logic i_tx
);

    int unsigned failures = 0;    // Summed up at end of run

    a_operands_pulse: assert property (@(posedge i_clk) disable iff (!i_rst)
        i_operands_valid |=> !i_operands_valid)
    else
    begin
        $error("operands_valid lasted more than one cycle");
        failures++;
    end

    a_result_pulse: assert property (@(posedge i_clk) disable iff (!i_rst)
        i_result_valid |=> !i_result_valid)
    else
    begin
        $error("result_valid lasted more than one cycle");
        failures++;
    end

    // ALU latency is exactly one cycle, both ways
    a_result_follows: assert property (@(posedge i_clk) disable iff (!i_rst)
        i_operands_valid |=> i_result_valid)
    else
    begin
        $error("result_valid missing one cycle after operands_valid");
        failures++;
    end

    a_result_cause: assert property (@(posedge i_clk) disable iff (!i_rst)
        i_result_valid |-> $past(i_operands_valid))
    else
    begin
        $error("result_valid without operands_valid one cycle earlier");
        failures++;
    end

    a_line_idle: assert property (@(posedge i_clk) disable iff (!i_rst)
        !i_tx_busy |-> i_tx)
    else
    begin
        $error("o_tx low while transmitter is not busy");
        failures++;
    end

endmodule

bind uart_alu_top uart_alu_properties u_props (
    .i_clk            (i_clk),
    .i_rst            (i_rst),
    .i_operands_valid (operands_valid),
    .i_result_valid   (result_valid),
    .i_tx_busy        (tx_busy),
    .i_tx             (o_tx)
);

// ==== verification/uart_alu_tb.sv ====
`timescale 1ns/1ps

module uart_alu_tb
    import uart_alu_pkg::*;
();

    logic clk;
    logic rst;
    logic rx_line;
    logic tx_line;

    logic [15:0]        lfsr_state = 16'd90;
    logic [NB_DATA-1:0] expected_q [$];    // Model results still to come back
    int                 reply_count = 0;
    int                 n_invalid = 6;
    int                 n_back_to_back = 8;

    tb_clock_gen u_clock_gen (
        .o_clk (clk),
        .o_rst (rst)
    );

    uart_alu_top UUT (
        .i_clk (clk),
        .i_rst (rst),
        .i_rx  (rx_line),
        .o_tx  (tx_line)
    );

    function automatic int bit_clks();
        return OVERSAMPLE * CLKS_PER_TICK;
    endfunction

    function automatic int frame_clks();
        return (NB_DATA + 2) * bit_clks();    // Start bit, data bits and stop bit
    endfunction

    // Galois form with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        if (state[0])
            return (state >> 1) ^ 16'hB400;
        else
            return state >> 1;
    endfunction

    function automatic logic [NB_DATA-1:0] draw_bits(input int nbits);
        logic [NB_DATA-1:0] value;
        value = '0;
        for (int i = 0; i < nbits; i++)
        begin
            value      = {value[NB_DATA-2:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return value;
    endfunction

    function automatic logic [NB_OPCODE-1:0] listed_op(input logic [2:0] idx);
        case (idx)
            3'd0:    return OP_ADD;
            3'd1:    return OP_SUB;
            3'd2:    return OP_AND;
            3'd3:    return OP_OR;
            3'd4:    return OP_XOR;
            3'd5:    return OP_SRA;
            3'd6:    return OP_SRL;
            default: return OP_NOR;
        endcase
    endfunction

    function automatic logic is_listed(input logic [NB_OPCODE-1:0] op);
        logic found;
        found = 1'b0;
        for (int i = 0; i < 8; i++)
        begin
            if (listed_op(3'(i)) == op)
                found = 1'b1;
        end
        return found;
    endfunction

    // Expected ALU result
    function automatic logic [NB_DATA-1:0] model_alu(input logic [NB_DATA-1:0] a,
                                                     input logic [NB_DATA-1:0] b,
                                                     input logic [NB_OPCODE-1:0] op);
        logic [2*NB_DATA-1:0] wide;
        logic [NB_DATA-1:0]   r;
        case (op)
            OP_ADD:  r = a + b;
            OP_SUB:  r = a + (~b) + 8'd1;
            OP_AND:  r = a & b;
            OP_OR:   r = a | b;
            OP_XOR:  r = a ^ b;
            OP_SRA:
            begin
                wide = {{NB_DATA{a[NB_DATA-1]}}, a};    // Sign extended for SRA
                wide = wide >> b[2:0];
                r    = wide[NB_DATA-1:0];
            end
            OP_SRL:  r = a >> b[2:0];
            OP_NOR:  r = ~a & ~b;
            default: r = '0;
        endcase
        return r;
    endfunction

    task automatic stop_with_failure();
        $display("Test failed");
        $fatal(1, "Run stopped at first failure");
    endtask

    task automatic check_result(input logic [NB_DATA-1:0] got,
                                input logic [NB_DATA-1:0] exp,
                                input string what);
        if (got !== exp)
        begin
            $display("[ERROR] %0t: %s is %02h, expected %02h", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_line(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    // Called on a falling edge and returns on one
    task automatic hold_line(input logic level);
        rx_line = level;
        repeat (bit_clks()) @(negedge clk);
    endtask

    task automatic send_byte(input logic [NB_DATA-1:0] data, input logic stop_bit);
        hold_line(1'b0);
        for (int i = 0; i < NB_DATA; i++)
            hold_line(data[i]);
        hold_line(stop_bit);
    endtask

    task automatic send_triple(input logic [NB_DATA-1:0] a,
                               input logic [NB_DATA-1:0] b,
                               input logic [NB_DATA-1:0] third);
        expected_q.push_back(model_alu(a, b, third[NB_OPCODE-1:0]));
        send_byte(a, 1'b1);
        send_byte(b, 1'b1);
        send_byte(third, 1'b1);
    endtask

    task automatic drain_replies();
        while (expected_q.size() != 0)
            @(negedge clk);
    endtask

    task automatic quiet_line(input int frames);
        repeat (frames * frame_clks())
        begin
            @(negedge clk);
            check_line(tx_line, 1'b1, "idle o_tx");
        end
    endtask

    // Serial monitor takes one reply byte per pass
    initial
    begin : serial_monitor
        logic [NB_DATA-1:0] got;
        logic [NB_DATA-1:0] exp;
        forever
        begin
            @(negedge clk);
            if (rst && !tx_line)
            begin
                repeat (bit_clks() / 2) @(negedge clk);    // Middle of start bit
                check_line(tx_line, 1'b0, "start bit");
                for (int i = 0; i < NB_DATA; i++)
                begin
                    repeat (bit_clks()) @(negedge clk);
                    got[i] = tx_line;
                end
                repeat (bit_clks()) @(negedge clk);
                check_line(tx_line, 1'b1, "stop bit");
                reply_count++;
                if (expected_q.size() == 0)
                begin
                    $display("Reply byte %02h came back with no request outstanding", got);
                    stop_with_failure();
                end
                else
                begin
                    exp = expected_q.pop_front();
                    check_result(got, exp, $sformatf("reply %0d", reply_count));
                end
            end
        end
    end

    initial
    begin : watchdog
        int limit;
        limit = ((8 + n_invalid + n_back_to_back + 1) * 4 + 24) * frame_clks();
        repeat (limit) @(posedge clk);
        $display("Timeout: tests did not finish within %0d clocks", limit);
        stop_with_failure();
    end

    initial
    begin : stimulus
        logic [NB_DATA-1:0]   a;
        logic [NB_DATA-1:0]   b;
        logic [NB_DATA-1:0]   raw;
        logic [NB_DATA-1:0]   hi;
        logic [NB_OPCODE-1:0] op;
        rx_line = 1'b1;
        @(posedge rst);
        @(negedge clk);

        quiet_line(3);    // Nothing may come back on an idle line

        for (int i = 0; i < 8; i++)
        begin
            a  = draw_bits(NB_DATA);
            b  = draw_bits(NB_DATA);
            hi = draw_bits(2);    // Upper bits of opcode byte are ignored
            send_triple(a, b, {hi[1:0], listed_op(3'(i))});
            drain_replies();
        end
        quiet_line(2);

        repeat (n_invalid)
        begin
            do
            begin
                raw = draw_bits(NB_OPCODE);
                op  = raw[NB_OPCODE-1:0];
            end
            while (is_listed(op));
            a  = draw_bits(NB_DATA);
            b  = draw_bits(NB_DATA);
            hi = draw_bits(2);
            send_triple(a, b, {hi[1:0], op});
            drain_replies();
        end
        quiet_line(2);

        // Triples with no gap so replies overlap the next triple
        repeat (n_back_to_back)
        begin
            a   = draw_bits(NB_DATA);
            b   = draw_bits(NB_DATA);
            raw = draw_bits(3);
            hi  = draw_bits(2);
            send_triple(a, b, {hi[1:0], listed_op(raw[2:0])});
        end
        drain_replies();
        quiet_line(2);

        raw = draw_bits(NB_DATA);
        send_byte(raw, 1'b0);    // Framing error that must be dropped
        hold_line(1'b1);
        a   = draw_bits(NB_DATA);
        b   = draw_bits(NB_DATA);
        raw = draw_bits(3);
        send_triple(a, b, {2'b00, listed_op(raw[2:0])});
        drain_replies();
        quiet_line(2);

        if (UUT.u_props.failures != 0)
        begin
            $display("Bound assertions failed %0d times", UUT.u_props.failures);
            stop_with_failure();
        end
        else
        begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

// ==== all.f ====
hdl/uart_alu_pkg.sv
hdl/baud_tick_gen.sv
hdl/uart_rx.sv
hdl/rx_operand_collector.sv
hdl/alu.sv
hdl/uart_tx.sv
hdl/uart_alu_top.sv
verification/tb_clock_gen.sv
verification/uart_alu_properties.sv
verification/uart_alu_tb.sv

// ==== Makefile ====
TOP := uart_alu_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 -f all.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir
